// ==== hdl/lsu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store unit top: decode, execute, store queue
// and data RAM, with results on the common data bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module lsu #(
    parameter int SQ_DEPTH  = 8,
    parameter int RAM_DEPTH = 256
) (
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 i_flush,

    input  logic                 i_fu_valid,
    input  lsu_pkg::lsu_opcode_t i_fu_opcode,
    input  lsu_pkg::lsu_data_t   i_fu_insn,
    input  lsu_pkg::lsu_data_t   i_fu_src_a,
    input  lsu_pkg::lsu_data_t   i_fu_src_b,
    input  lsu_pkg::lsu_tag_t    i_fu_tag,
    output logic                 o_fu_stall,

    input  lsu_pkg::lsu_tag_t    i_rob_retire_tag,
    input  logic                 i_rob_retire_sq_en,
    output logic                 o_rob_retire_stall,

    output logic                 o_cdb_en,
    output lsu_pkg::lsu_data_t   o_cdb_data,
    output lsu_pkg::lsu_addr_t   o_cdb_addr,
    output lsu_pkg::lsu_tag_t    o_cdb_tag
);
    import lsu_pkg::*;

    localparam int RAM_AW = $clog2(RAM_DEPTH);

    logic         sq_full;
    logic         fu_accept;
    lsu_func_t    id_func;
    lsu_addr_t    id_addr;
    lsu_tag_t     id_tag;
    logic         id_valid;
    lsu_func_t    id_func_q;
    lsu_addr_t    id_addr_q;
    lsu_tag_t     id_tag_q;
    logic         id_valid_q;
    lsu_data_t    ex_data;
    lsu_addr_t    ex_addr;
    lsu_tag_t     ex_tag;
    logic         ex_valid;
    lsu_data_t    ex_data_q;
    lsu_addr_t    ex_addr_q;
    lsu_tag_t     ex_tag_q;
    logic         ex_valid_q;
    logic         alloc_en;
    lsu_func_t    alloc_func;
    lsu_addr_t    alloc_addr;
    lsu_data_t    alloc_data;
    lsu_tag_t     alloc_tag;
    logic         ram_rd_en;
    lsu_addr_t    ram_rd_addr;
    lsu_data_t    ram_rd_data;
    logic         sq_wr_en;
    lsu_addr_t    sq_wr_addr;
    lsu_data_t    sq_wr_data;
    lsu_byte_en_t sq_byte_en;

    // Loads stall on a full queue too, keeping issue in order
    assign o_fu_stall = sq_full;
    assign fu_accept  = i_fu_valid && !sq_full;

    assign o_cdb_en   = ex_valid_q;
    assign o_cdb_data = ex_data_q;
    assign o_cdb_addr = ex_addr_q;
    assign o_cdb_tag  = ex_tag_q;

    always_ff @(posedge clk) begin
        id_func_q <= id_func;
        id_addr_q <= id_addr;
        id_tag_q  <= id_tag;
        ex_data_q <= ex_data;
        ex_addr_q <= ex_addr;
        ex_tag_q  <= ex_tag;
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            id_valid_q <= 1'b0;
            ex_valid_q <= 1'b0;
        end else begin
            id_valid_q <= id_valid && !i_flush;
            ex_valid_q <= ex_valid && !i_flush;
        end
    end

    lsu_id lsu_id_inst (
        .clk(clk),
        .n_rst(n_rst),
        .i_valid(fu_accept),
        .i_opcode(i_fu_opcode),
        .i_insn(i_fu_insn),
        .i_src_a(i_fu_src_a),
        .i_src_b(i_fu_src_b),
        .i_tag(i_fu_tag),
        .o_func(id_func),
        .o_addr(id_addr),
        .o_tag(id_tag),
        .o_valid(id_valid),
        .o_alloc_en(alloc_en),
        .o_alloc_func(alloc_func),
        .o_alloc_addr(alloc_addr),
        .o_alloc_data(alloc_data),
        .o_alloc_tag(alloc_tag)
    );

    // A load in the RAM read stage is dropped on flush as well
    lsu_ex lsu_ex_inst (
        .clk(clk),
        .n_rst(n_rst),
        .i_func(id_func_q),
        .i_addr(id_addr_q),
        .i_tag(id_tag_q),
        .i_valid(id_valid_q && !i_flush),
        .o_data(ex_data),
        .o_addr(ex_addr),
        .o_tag(ex_tag),
        .o_valid(ex_valid),
        .o_ram_rd_en(ram_rd_en),
        .o_ram_rd_addr(ram_rd_addr),
        .i_ram_rd_data(ram_rd_data)
    );

    lsu_sq #(
        .SQ_DEPTH(SQ_DEPTH)
    ) lsu_sq_inst (
        .clk(clk),
        .n_rst(n_rst),
        .i_flush(i_flush),
        .o_full(sq_full),
        .i_alloc_en(alloc_en),
        .i_alloc_func(alloc_func),
        .i_alloc_addr(alloc_addr),
        .i_alloc_data(alloc_data),
        .i_alloc_tag(alloc_tag),
        .i_retire_en(i_rob_retire_sq_en),
        .i_retire_tag(i_rob_retire_tag),
        .o_retire_stall(o_rob_retire_stall),
        .o_wr_en(sq_wr_en),
        .o_wr_addr(sq_wr_addr),
        .o_wr_data(sq_wr_data),
        .o_wr_byte_en(sq_byte_en)
    );

    lsu_data_ram #(
        .RAM_DEPTH(RAM_DEPTH)
    ) lsu_data_ram_inst (
        .clk(clk),
        .i_rd_en(ram_rd_en),
        .i_rd_addr(ram_rd_addr[RAM_AW-1:0]),
        .o_rd_data(ram_rd_data),
        .i_wr_en(sq_wr_en),
        .i_wr_addr(sq_wr_addr[RAM_AW-1:0]),
        .i_wr_byte_en(sq_byte_en),
        .i_wr_data(sq_wr_data)
    );

endmodule

// ==== hdl/lsu_data_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data RAM, one registered read and one write with
// byte enables per cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module lsu_data_ram #(
    parameter int RAM_DEPTH = 256
) (
    input  logic                         clk,

    input  logic                         i_rd_en,
    input  logic [$clog2(RAM_DEPTH)-1:0] i_rd_addr,
    output lsu_pkg::lsu_data_t           o_rd_data,

    input  logic                         i_wr_en,
    input  logic [$clog2(RAM_DEPTH)-1:0] i_wr_addr,
    input  lsu_pkg::lsu_byte_en_t        i_wr_byte_en,
    input  lsu_pkg::lsu_data_t           i_wr_data
);
    import lsu_pkg::*;

    lsu_data_t mem [RAM_DEPTH];

    initial begin
        for (int i = 0; i < RAM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < DATA_WIDTH/8; b++) begin
            if (i_wr_en && i_wr_byte_en[b]) begin
                mem[i_wr_addr][8*b +: 8] <= i_wr_data[8*b +: 8];
            end
        end
    end

endmodule

// ==== hdl/lsu_ex.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage: RAM read for a load, then lane
// select and sign or zero extension of the word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module lsu_ex (
    input  logic               clk,
    input  logic               n_rst,

    input  lsu_pkg::lsu_func_t i_func,
    input  lsu_pkg::lsu_addr_t i_addr,
    input  lsu_pkg::lsu_tag_t  i_tag,
    input  logic               i_valid,

    output lsu_pkg::lsu_data_t o_data,
    output lsu_pkg::lsu_addr_t o_addr,
    output lsu_pkg::lsu_tag_t  o_tag,
    output logic               o_valid,

    output logic               o_ram_rd_en,
    output lsu_pkg::lsu_addr_t o_ram_rd_addr,
    input  lsu_pkg::lsu_data_t i_ram_rd_data
);
    import lsu_pkg::*;

    lsu_func_t  func_q;
    lsu_addr_t  addr_q;
    lsu_tag_t   tag_q;
    logic       valid_q;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // Word index
    assign o_ram_rd_en   = i_valid;
    assign o_ram_rd_addr = {2'b00, i_addr[ADDR_WIDTH-1:2]};

    // Held while the RAM answers
    always_ff @(posedge clk) begin
        func_q <= i_func;
        addr_q <= i_addr;
        tag_q  <= i_tag;
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_valid;
        end
    end

    assign byte_sel = 8'(i_ram_rd_data >> {addr_q[1:0], 3'b000});
    assign half_sel = addr_q[1] ? i_ram_rd_data[31:16] : i_ram_rd_data[15:0];

    always_comb begin
        case (func_q)
            LSU_FUNC_LB:  o_data = {{24{byte_sel[7]}}, byte_sel};
            LSU_FUNC_LBU: o_data = {24'b0, byte_sel};
            LSU_FUNC_LH:  o_data = {{16{half_sel[15]}}, half_sel};
            LSU_FUNC_LHU: o_data = {16'b0, half_sel};
            default:      o_data = i_ram_rd_data;
        endcase
    end

    assign o_addr  = addr_q;
    assign o_tag   = tag_q;
    assign o_valid = valid_q;

endmodule

// ==== hdl/lsu_id.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage: function decode, effective address,
// load issue and store queue allocation
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module lsu_id (
    input  logic                 clk,
    input  logic                 n_rst,

    input  logic                 i_valid,
    input  lsu_pkg::lsu_opcode_t i_opcode,
    input  lsu_pkg::lsu_data_t   i_insn,
    input  lsu_pkg::lsu_data_t   i_src_a,
    input  lsu_pkg::lsu_data_t   i_src_b,
    input  lsu_pkg::lsu_tag_t    i_tag,

    output lsu_pkg::lsu_func_t   o_func,
    output lsu_pkg::lsu_addr_t   o_addr,
    output lsu_pkg::lsu_tag_t    o_tag,
    output logic                 o_valid,

    output logic                 o_alloc_en,
    output lsu_pkg::lsu_func_t   o_alloc_func,
    output lsu_pkg::lsu_addr_t   o_alloc_addr,
    output lsu_pkg::lsu_data_t   o_alloc_data,
    output lsu_pkg::lsu_tag_t    o_alloc_tag
);
    import lsu_pkg::*;

    logic        is_load;
    logic        is_store;
    logic [11:0] imm;
    lsu_func_t   func;
    lsu_addr_t   addr;

    assign is_load  = (i_opcode == OPCODE_LOAD);
    assign is_store = (i_opcode == OPCODE_STORE);

    // I-type immediate for loads, S-type for stores
    assign imm  = is_store ? {i_insn[31:25], i_insn[11:7]} : i_insn[31:20];
    assign addr = i_src_a + {{(ADDR_WIDTH-12){imm[11]}}, imm};
    assign func = lsu_func_t'({is_store, i_insn[14:12]});

    assign o_func  = func;
    assign o_addr  = addr;
    assign o_tag   = i_tag;
    assign o_valid = i_valid && is_load;

    assign o_alloc_en   = i_valid && is_store;
    assign o_alloc_func = func;
    assign o_alloc_addr = addr;
    assign o_alloc_data = i_src_b;
    assign o_alloc_tag  = i_tag;

    // Only loads and stores are issued to this unit
    a_known_op: assert property (@(posedge clk) disable iff (!n_rst)
        i_valid |-> (is_load || is_store))
        else $error("micro-op with an opcode that is neither load nor store");

endmodule

// ==== hdl/lsu_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths, opcodes and load/store function codes
// shared by the load/store unit RTL and its testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package lsu_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;
    localparam int TAG_WIDTH  = 6;

    typedef logic [DATA_WIDTH-1:0]   lsu_data_t;
    typedef logic [ADDR_WIDTH-1:0]   lsu_addr_t;
    typedef logic [TAG_WIDTH-1:0]    lsu_tag_t;
    typedef logic [DATA_WIDTH/8-1:0] lsu_byte_en_t;

    // RISC-V major opcodes
    typedef enum logic [6:0] {
        OPCODE_LOAD  = 7'b0000011,
        OPCODE_STORE = 7'b0100011
    } lsu_opcode_t;

    // Store flag on top of funct3
    typedef enum logic [3:0] {
        LSU_FUNC_LB  = 4'b0000,
        LSU_FUNC_LH  = 4'b0001,
        LSU_FUNC_LW  = 4'b0010,
        LSU_FUNC_LBU = 4'b0100,
        LSU_FUNC_LHU = 4'b0101,
        LSU_FUNC_SB  = 4'b1000,
        LSU_FUNC_SH  = 4'b1001,
        LSU_FUNC_SW  = 4'b1010
    } lsu_func_t;

endpackage

// ==== hdl/lsu_sq.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Store queue: holds stores until retired by tag,
// then drains them to the data RAM in order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module lsu_sq #(
    parameter int SQ_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  i_flush,
    output logic                  o_full,

    input  logic                  i_alloc_en,
    input  lsu_pkg::lsu_func_t    i_alloc_func,
    input  lsu_pkg::lsu_addr_t    i_alloc_addr,
    input  lsu_pkg::lsu_data_t    i_alloc_data,
    input  lsu_pkg::lsu_tag_t     i_alloc_tag,

    input  logic                  i_retire_en,
    input  lsu_pkg::lsu_tag_t     i_retire_tag,
    output logic                  o_retire_stall,

    output logic                  o_wr_en,
    output lsu_pkg::lsu_addr_t    o_wr_addr,
    output lsu_pkg::lsu_data_t    o_wr_data,
    output lsu_pkg::lsu_byte_en_t o_wr_byte_en
);
    import lsu_pkg::*;

    localparam int PTR_W = $clog2(SQ_DEPTH);

    lsu_func_t entry_func [SQ_DEPTH];
    lsu_addr_t entry_addr [SQ_DEPTH];
    lsu_data_t entry_data [SQ_DEPTH];
    lsu_tag_t  entry_tag  [SQ_DEPTH];

    logic [SQ_DEPTH-1:0] entry_valid;
    logic [SQ_DEPTH-1:0] entry_retired;
    logic [PTR_W-1:0]    head;
    logic [PTR_W-1:0]    tail;

    logic [SQ_DEPTH-1:0] retire_match;
    logic [PTR_W-1:0]    retire_idx;
    logic                retire_ok;
    logic [SQ_DEPTH-1:0] retired_upd;
    logic [SQ_DEPTH-1:0] valid_next;
    logic [SQ_DEPTH-1:0] retired_next;
    logic [PTR_W:0]      keep_cnt;
    logic                alloc;
    lsu_addr_t           head_addr;

    assign o_full    = entry_valid[tail];
    assign alloc     = i_alloc_en && !i_flush;
    assign o_wr_en   = entry_valid[head] && entry_retired[head];
    assign head_addr = entry_addr[head];

    // Tag search over live, unretired entries
    always_comb begin
        retire_idx = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            retire_match[i] = entry_valid[i] && !entry_retired[i]
                              && (entry_tag[i] == i_retire_tag);
            if (retire_match[i]) begin
                retire_idx = PTR_W'(i);
            end
        end
    end

    assign retire_ok      = i_retire_en && (|retire_match);
    assign o_retire_stall = i_retire_en && !(|retire_match);
    assign retired_upd    = entry_retired | (retire_ok ? retire_match : '0);

    // Retired entries are a prefix from head, so the count locates the new tail
    always_comb begin
        keep_cnt     = '0;
        valid_next   = entry_valid;
        retired_next = retired_upd;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            keep_cnt = keep_cnt + {{PTR_W{1'b0}}, entry_valid[i] & retired_upd[i]};
        end
        if (i_flush) begin
            valid_next = entry_valid & retired_upd;
        end
        if (o_wr_en) begin
            valid_next[head]   = 1'b0;
            retired_next[head] = 1'b0;
        end
        if (alloc) begin
            valid_next[tail]   = 1'b1;
            retired_next[tail] = 1'b0;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            head          <= '0;
            tail          <= '0;
            entry_valid   <= '0;
            entry_retired <= '0;
        end else begin
            entry_valid   <= valid_next;
            entry_retired <= retired_next;
            if (o_wr_en) begin
                head <= head + 1'b1;
            end
            if (i_flush) begin
                tail <= head + keep_cnt[PTR_W-1:0];
            end else if (alloc) begin
                tail <= tail + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            entry_func[tail] <= i_alloc_func;
            entry_addr[tail] <= i_alloc_addr;
            entry_data[tail] <= i_alloc_data;
            entry_tag[tail]  <= i_alloc_tag;
        end
    end

    // Move store data into its byte lanes
    always_comb begin
        case (entry_func[head])
            LSU_FUNC_SB: begin
                o_wr_byte_en = 4'b0001 << head_addr[1:0];
                o_wr_data    = entry_data[head] << {head_addr[1:0], 3'b000};
            end
            LSU_FUNC_SH: begin
                o_wr_byte_en = 4'b0011 << {head_addr[1], 1'b0};
                o_wr_data    = entry_data[head] << {head_addr[1], 4'b0000};
            end
            default: begin
                o_wr_byte_en = 4'b1111;
                o_wr_data    = entry_data[head];
            end
        endcase
    end

    assign o_wr_addr = {2'b00, head_addr[ADDR_WIDTH-1:2]};

    // Issue must already be held off by the stall
    a_no_alloc_full: assert property (@(posedge clk) disable iff (!n_rst)
        i_alloc_en |-> !o_full)
        else $error("store allocated into a full queue");

    // In-order retire keeps the drain from waiting on an unretired head
    a_retire_order: assert property (@(posedge clk) disable iff (!n_rst)
        retire_ok |-> (retire_idx == head) || entry_retired[retire_idx - 1'b1])
        else $error("store retired ahead of an older unretired store");

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the load/store unit testbench with Verilator and run it.
# The exit status is the simulator's, nonzero on any failure.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module lsu_tb -o lsu_sim
./obj_dir/lsu_sim

// ==== tb.f ====
hdl/lsu_pkg.sv
hdl/lsu_id.sv
hdl/lsu_ex.sv
hdl/lsu_sq.sv
hdl/lsu_data_ram.sv
hdl/lsu.sv
tests/lsu_tb.sv

// ==== tests/lsu_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store unit testbench, driven by the operations
// in tests/lsu_trace.txt; run from the project root
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module lsu_tb;
    import lsu_pkg::*;

    localparam int SQ_DEPTH  = 8;
    localparam int RAM_DEPTH = 256;

    typedef struct {
        lsu_data_t data;
        lsu_addr_t addr;
        lsu_tag_t  tag;
        int        cyc;
    } load_exp_t;

    logic        clk;
    logic        n_rst;
    logic        i_flush;
    logic        i_fu_valid;
    lsu_opcode_t i_fu_opcode;
    lsu_data_t   i_fu_insn;
    lsu_data_t   i_fu_src_a;
    lsu_data_t   i_fu_src_b;
    lsu_tag_t    i_fu_tag;
    logic        o_fu_stall;
    lsu_tag_t    i_rob_retire_tag;
    logic        i_rob_retire_sq_en;
    logic        o_rob_retire_stall;
    logic        o_cdb_en;
    lsu_data_t   o_cdb_data;
    lsu_addr_t   o_cdb_addr;
    lsu_tag_t    o_cdb_tag;

    // Reference memory and stores waiting for retire, by tag
    lsu_data_t ref_mem [RAM_DEPTH];
    lsu_func_t st_func [64];
    lsu_addr_t st_addr [64];
    lsu_data_t st_data [64];
    logic      st_live [64];

    load_exp_t exp_q [$];
    string     test_name = "reset";
    int        cycles = 0;
    int        limit = 1000;
    int        pending = 0;
    int        unret = 0;
    logic      last_accept;
    logic      retire_stall_exp;
    lsu_func_t op_func;
    lsu_addr_t op_addr;
    lsu_data_t op_data;
    lsu_tag_t  op_tag;
    lsu_data_t op_exp;

    lsu DUT (
        .clk(clk),
        .n_rst(n_rst),
        .i_flush(i_flush),
        .i_fu_valid(i_fu_valid),
        .i_fu_opcode(i_fu_opcode),
        .i_fu_insn(i_fu_insn),
        .i_fu_src_a(i_fu_src_a),
        .i_fu_src_b(i_fu_src_b),
        .i_fu_tag(i_fu_tag),
        .o_fu_stall(o_fu_stall),
        .i_rob_retire_tag(i_rob_retire_tag),
        .i_rob_retire_sq_en(i_rob_retire_sq_en),
        .o_rob_retire_stall(o_rob_retire_stall),
        .o_cdb_en(o_cdb_en),
        .o_cdb_data(o_cdb_data),
        .o_cdb_addr(o_cdb_addr),
        .o_cdb_tag(o_cdb_tag)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout after %0d cycles, %0d load results outstanding",
                     cycles, exp_q.size());
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    task automatic report_mismatch(input string what, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp_val, act_val);
        $display("Testbench failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_failure(input string what);
        $display("Error in test %s: %s", test_name, what);
        $display("Testbench failed");
        $fatal(1, "check failed");
    endtask

    function automatic lsu_func_t func_from_name(input string name);
        if (name == "lb") return LSU_FUNC_LB;
        if (name == "lh") return LSU_FUNC_LH;
        if (name == "lbu") return LSU_FUNC_LBU;
        if (name == "lhu") return LSU_FUNC_LHU;
        if (name == "sb") return LSU_FUNC_SB;
        if (name == "sh") return LSU_FUNC_SH;
        if (name == "sw") return LSU_FUNC_SW;
        return LSU_FUNC_LW;
    endfunction

    // I-type for loads, S-type for stores; rs1 = x1, rs2 = x2, rd = x3
    function automatic lsu_data_t build_insn(input lsu_func_t func, input logic [11:0] imm);
        if (func[3]) begin
            return {imm[11:5], 5'd2, 5'd1, func[2:0], imm[4:0], OPCODE_STORE};
        end
        return {imm, 5'd1, func[2:0], 5'd3, OPCODE_LOAD};
    endfunction

    function automatic int word_index(input lsu_addr_t addr);
        return int'((addr >> 2) % RAM_DEPTH);
    endfunction

    function automatic lsu_data_t load_value(input lsu_func_t func, input lsu_data_t word,
                                             input logic [1:0] ofs);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*ofs +: 8];
        h = word[16*ofs[1] +: 16];
        case (func)
            LSU_FUNC_LB:  return {{24{b[7]}}, b};
            LSU_FUNC_LBU: return {24'b0, b};
            LSU_FUNC_LH:  return {{16{h[15]}}, h};
            LSU_FUNC_LHU: return {16'b0, h};
            default:      return word;
        endcase
    endfunction

    function automatic void store_to_ref(input lsu_tag_t tag);
        lsu_addr_t a;
        int        w;
        a = st_addr[tag];
        w = word_index(a);
        case (st_func[tag])
            LSU_FUNC_SB: ref_mem[w][8*a[1:0] +: 8] = st_data[tag][7:0];
            LSU_FUNC_SH: ref_mem[w][16*a[1] +: 16] = st_data[tag][15:0];
            default:     ref_mem[w] = st_data[tag];
        endcase
    endfunction

    // Checks mid-cycle, then moves the queue model across the next edge
    task automatic step_cycle();
        logic      accept;
        logic      load_acc;
        logic      store_acc;
        logic      retire_ok;
        logic      flush_now;
        lsu_tag_t  ret_tag;
        load_exp_t e;
        @(negedge clk);
        accept    = i_fu_valid && !o_fu_stall;
        load_acc  = accept && (i_fu_opcode == OPCODE_LOAD);
        store_acc = accept && (i_fu_opcode == OPCODE_STORE);
        retire_ok = i_rob_retire_sq_en && !retire_stall_exp;
        ret_tag   = i_rob_retire_tag;
        flush_now = i_flush;
        assert (o_fu_stall == ((pending + unret) == SQ_DEPTH))
            else report_mismatch("o_fu_stall", 32'((pending + unret) == SQ_DEPTH),
                                 32'(o_fu_stall));
        assert (o_rob_retire_stall == (i_rob_retire_sq_en && retire_stall_exp))
            else report_mismatch("o_rob_retire_stall",
                                 32'(i_rob_retire_sq_en && retire_stall_exp),
                                 32'(o_rob_retire_stall));
        if (o_cdb_en) begin
            assert (exp_q.size() > 0) else report_failure("CDB result with no load outstanding");
            e = exp_q.pop_front();
            assert (cycles == e.cyc) else report_mismatch("cdb cycle", 32'(e.cyc), 32'(cycles));
            assert (o_cdb_tag == e.tag) else report_mismatch("cdb tag", 32'(e.tag), 32'(o_cdb_tag));
            assert (o_cdb_addr == e.addr) else report_mismatch("cdb addr", e.addr, o_cdb_addr);
            assert (o_cdb_data == e.data) else report_mismatch("cdb data", e.data, o_cdb_data);
        end else begin
            assert (exp_q.size() == 0 || exp_q[0].cyc > cycles)
                else report_failure("load result did not appear on the CDB");
        end
        @(posedge clk);
        #10;
        // Retired head drains one per edge
        if (pending > 0) begin
            pending--;
        end
        if (store_acc) begin
            st_func[op_tag] = op_func;
            st_addr[op_tag] = op_addr;
            st_data[op_tag] = op_data;
            st_live[op_tag] = 1'b1;
            unret++;
        end
        if (load_acc) begin
            e.data = op_exp;
            e.addr = op_addr;
            e.tag  = op_tag;
            e.cyc  = cycles + 2;
            exp_q.push_back(e);
        end
        if (retire_ok) begin
            store_to_ref(ret_tag);
            st_live[ret_tag] = 1'b0;
            unret--;
            pending++;
        end
        if (flush_now) begin
            unret = 0;
            foreach (st_live[i]) st_live[i] = 1'b0;
        end
        last_accept = accept;
    endtask

    task automatic issue_op(input lsu_func_t func, input lsu_addr_t base, input logic [11:0] imm,
                            input lsu_data_t data, input lsu_tag_t tag, input lsu_data_t exp_data);
        lsu_data_t ref_val;
        op_func = func;
        op_addr = base + {{20{imm[11]}}, imm};
        op_data = data;
        op_tag  = tag;
        op_exp  = exp_data;
        if (!func[3]) begin
            ref_val = load_value(func, ref_mem[word_index(op_addr)], op_addr[1:0]);
            assert (exp_data == ref_val)
                else report_mismatch("trace load value vs reference memory", ref_val, exp_data);
        end
        if (func[3]) begin
            i_fu_opcode = OPCODE_STORE;
        end else begin
            i_fu_opcode = OPCODE_LOAD;
        end
        i_fu_valid = 1'b1;
        i_fu_insn  = build_insn(func, imm);
        i_fu_src_a = base;
        i_fu_src_b = data;
        i_fu_tag   = tag;
        last_accept = 1'b0;
        while (!last_accept) begin
            step_cycle();
        end
        i_fu_valid = 1'b0;
    endtask

    task automatic do_retire(input lsu_tag_t tag, input logic exp_stall);
        assert (exp_stall == !st_live[tag])
            else report_mismatch("trace retire stall vs model", 32'(!st_live[tag]),
                                 32'(exp_stall));
        retire_stall_exp   = exp_stall;
        i_rob_retire_sq_en = 1'b1;
        i_rob_retire_tag   = tag;
        step_cycle();
        i_rob_retire_sq_en = 1'b0;
    endtask

    task automatic run_line(input string line);
        string       op;
        string       name;
        lsu_addr_t   base;
        logic [11:0] imm;
        lsu_data_t   data;
        lsu_tag_t    tag;
        int          num;
        int          n;
        n = $sscanf(line, "%s", op);
        if (op == "test") begin
            n = $sscanf(line, "%s %s", op, test_name);
        end else if (op == "load") begin
            n = $sscanf(line, "%s %s %h %h %h %h", op, name, base, imm, tag, data);
            assert (n == 6) else report_failure({"malformed load line: ", line});
            issue_op(func_from_name(name), base, imm, '0, tag, data);
        end else if (op == "store") begin
            n = $sscanf(line, "%s %s %h %h %h %h", op, name, base, imm, data, tag);
            assert (n == 6) else report_failure({"malformed store line: ", line});
            issue_op(func_from_name(name), base, imm, data, tag, '0);
        end else if (op == "retire") begin
            n = $sscanf(line, "%s %h %d", op, tag, num);
            assert (n == 3) else report_failure({"malformed retire line: ", line});
            do_retire(tag, num != 0);
        end else if (op == "flush") begin
            i_flush = 1'b1;
            step_cycle();
            i_flush = 1'b0;
        end else if (op == "idle") begin
            n = $sscanf(line, "%s %d", op, num);
            repeat (num) step_cycle();
        end else begin
            report_failure({"unknown trace operation: ", op});
        end
    endtask

    initial begin
        int    fd;
        int    num;
        int    len;
        string line;
        string op;
        string lines [$];
        n_rst              = 1'b0;
        i_flush            = 1'b0;
        i_fu_valid         = 1'b0;
        i_fu_opcode        = OPCODE_LOAD;
        i_fu_insn          = '0;
        i_fu_src_a         = '0;
        i_fu_src_b         = '0;
        i_fu_tag           = '0;
        i_rob_retire_tag   = '0;
        i_rob_retire_sq_en = 1'b0;
        retire_stall_exp   = 1'b0;
        foreach (ref_mem[i]) ref_mem[i] = '0;
        foreach (st_live[i]) st_live[i] = 1'b0;

        fd = $fopen("tests/lsu_trace.txt", "r");
        assert (fd != 0) else report_failure("cannot open tests/lsu_trace.txt");
        len = 0;
        while ($fgets(line, fd) > 0) begin
            if ($sscanf(line, "%s", op) == 1 && op.getc(0) != "#") begin
                lines.push_back(line);
                if (op == "idle" && $sscanf(line, "%s %d", op, num) == 2) begin
                    len += num;
                end else begin
                    len += 1;
                end
            end
        end
        $fclose(fd);
        limit = len * 4 + 100;

        repeat (16) @(posedge clk);
        #10;
        n_rst = 1'b1;

        foreach (lines[i]) run_line(lines[i]);
        test_name = "drain";
        while (exp_q.size() > 0) begin
            step_cycle();
        end
        repeat (2) step_cycle();
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== tests/lsu_trace.txt ====
# load <func> <base> <imm12> <tag> <expected> | store <func> <base> <imm12> <data> <tag>
# retire <tag> <stall> | flush | idle <cycles> | test <name>; numbers in hex except counts
test reset_idle
idle 4
test word_store_load
store sw 00000100 010 deadbeef 01
retire 01 0
idle 2
load lw 00000100 010 02 deadbeef
load lw 00000120 ff0 03 deadbeef
test sub_word
store sw 00000200 000 11223344 04
store sb 00000200 001 000000a5 05
store sh 00000200 002 0000807f 06
store sb 00000204 003 000000ff 07
retire 04 0
retire 05 0
retire 06 0
retire 07 0
idle 2
load lw 00000200 000 08 807fa544
load lb 00000200 001 09 ffffffa5
load lbu 00000200 001 0a 000000a5
load lb 00000200 000 0b 00000044
load lh 00000200 002 0c ffff807f
load lhu 00000200 002 0d 0000807f
load lh 00000200 000 0e ffffa544
load lb 00000204 003 0f ffffffff
load lbu 00000204 002 10 00000000
idle 4
test queue_full
store sw 00000300 000 00000001 11
store sw 00000300 004 00000002 12
store sw 00000300 008 00000003 13
store sw 00000300 00c 00000004 14
store sw 00000300 010 00000005 15
store sw 00000300 014 00000006 16
store sw 00000300 018 00000007 17
store sw 00000300 01c 00000008 18
retire 11 0
store sw 00000300 020 00000009 19
retire 12 0
retire 13 0
retire 14 0
retire 15 0
retire 16 0
retire 17 0
retire 18 0
retire 19 0
idle 2
load lw 00000300 020 1a 00000009
load lw 00000300 000 1b 00000001
load lw 00000300 01c 1c 00000008
idle 4
test flush
store sw 00000400 000 cafef00d 20
retire 20 0
store sw 00000400 004 12345678 21
store sw 00000400 000 bad0bad0 22
flush
retire 21 1
retire 22 1
idle 2
load lw 00000400 000 23 cafef00d
load lw 00000400 004 24 00000000
load lw 00000100 010 25 deadbeef
idle 4
